// File: src.f
source/cpuPkg.sv
source/ctrlIf.sv
source/control.sv
source/regFile.sv
source/alu.sv
source/dataMem.sv
source/cpuCore.sv
verification/tbClock.sv
verification/tbChecker.sv
verification/tbCpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbCpu
FILELIST  ?= src.f
FLAGS     ?= --binary --timing -j 0 --top-module $(TOP)
BUILD_DIR ?= obj_dir
LOG       ?= run.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench into $(LOG), check the result"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tbCpu.sv
`default_nettype none

module tbCpu import cpuPkg::*; ();

  localparam int MEM_BYTES       = 256;
  localparam int PROG_WORDS      = 64;
  localparam int PROG_IDX_W      = $clog2(PROG_WORDS);
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 80;
  localparam int RESET_TIMEOUT   = 20;
  localparam int WATCHDOG_CYCLES = 700;

  // Focus groups sit next to each other in this table
  localparam opcode_t LEGAL_OPS [9] = '{OP_ADD, OP_SUB, OP_MUL, OP_LDW, OP_STW,
                                        OP_LDB, OP_STB, OP_BEQ, OP_JUMP};

  logic        clk;
  logic        rstN;
  logic        startReset;
  word_t       pc;
  word_t       instr;
  logic        regWrEn;
  regAddr_t    regWrAddr;
  word_t       regWrData;
  logic        memWrEn;
  word_t       memAddr;
  word_t       memWrData;
  logic        memByte;
  logic        illegal;
  word_t       progMem [PROG_WORDS];
  logic [31:0] rngState;
  int          testsDone;
  int          errorCount;
  int          checkCount;
  int          failedTests;
  bit          timedOut;

  tbClock uClock (.startReset(startReset), .clk(clk), .rstN(rstN));

  cpuCore #(.MEM_BYTES(MEM_BYTES)) UUT (
    .clk(clk), .rstN(rstN), .pc(pc), .instr(instr),
    .regWrEn(regWrEn), .regWrAddr(regWrAddr), .regWrData(regWrData),
    .memWrEn(memWrEn), .memAddr(memAddr), .memWrData(memWrData),
    .memByte(memByte), .illegal(illegal)
  );

  tbChecker #(.PROG_WORDS(PROG_WORDS), .MEM_BYTES(MEM_BYTES)) uChecker (
    .clk(clk), .rstN(rstN), .prog(progMem), .pc(pc),
    .regWrEn(regWrEn), .regWrAddr(regWrAddr), .regWrData(regWrData),
    .memWrEn(memWrEn), .memAddr(memAddr), .memWrData(memWrData),
    .memByte(memByte), .illegal(illegal), .testsDone(testsDone),
    .errorCount(errorCount), .checkCount(checkCount), .failedTests(failedTests)
  );

  assign instr = progMem[pc[PROG_IDX_W+1:2]];   // Program wraps every 64 words

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRandom();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  // Focus 0 to 3 favour one instruction group, focus 4 mixes in more illegal codes
  function automatic logic [5:0] pickOpcode(input int focus);
    logic [31:0] r;
    int          idx;
    r = nextRandom();
    if (r[3:0] == 4'hF || (focus == 4 && r[3:0] >= 4'hC)) begin
      return {2'b10, r[7:4]};                    // 0x20 to 0x2F, never decoded
    end
    if (focus < 4 && r[3:0] < 4'h9) begin
      idx = (focus == 0) ? int'(r[9:8]) % 3 : 2 * focus + 1 + int'(r[8]);
    end else begin
      idx = int'(r[15:8]) % 9;
    end
    return LEGAL_OPS[idx];
  endfunction

  function automatic word_t makeInstr(input int focus, input int idx);
    logic [5:0]  op;
    logic [31:0] r;
    int          target;
    int          offset;
    word_t       ins;
    op     = pickOpcode(focus);
    r      = nextRandom();
    ins    = {op, r[25:0]};                      // Random register fields
    target = int'(r[31:26]);
    if (target == idx) begin
      target = (idx + 1) % PROG_WORDS;           // No branch onto itself
    end
    case (op)
      OP_LDB, OP_LDW, OP_STB, OP_STW: ins[15:0] = {{9{r[6]}}, r[6:0]};
      OP_BEQ: begin
        offset    = target - idx - 1;
        ins[15:0] = offset[15:0];
      end
      OP_JUMP: ins[25:0] = 26'(target);
      default: ;
    endcase
    return ins;
  endfunction

  task automatic waitResetRelease(output bit released);
    int waitCount;
    waitCount = 0;
    while (!rstN && waitCount < RESET_TIMEOUT) begin
      @(negedge clk);
      waitCount++;
    end
    released = rstN;
  endtask

  initial begin
    bit released;
    startReset = 1'b0;
    testsDone  = 0;
    timedOut   = 1'b0;
    rngState   = 32'd83;
    for (int i = 0; i < PROG_WORDS; i++) begin
      progMem[i] = '0;
    end
    @(posedge clk);
    #2;
    for (int t = 0; t < NUM_TESTS; t++) begin
      for (int i = 0; i < PROG_WORDS; i++) begin
        progMem[i] = makeInstr(t, i);
      end
      startReset = 1'b1;                         // Each mini-test starts from reset
      @(posedge clk);
      #2 startReset = 1'b0;
      waitResetRelease(released);
      if (!released) begin
        timedOut = 1'b1;
        break;
      end
      repeat (CYCLES_PER_TEST) @(posedge clk);
      #2;
      testsDone = testsDone + 1;
    end
    #1;
    if (timedOut) begin
      $display("Timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
    end
    $display("Summary: %0d of %0d tests run, %0d failed, %0d checks, %0d errors",
             testsDone, NUM_TESTS, failedTests, checkCount, errorCount);
    if (!timedOut && errorCount == 0 && checkCount > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < WATCHDOG_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: simulation still running after %0d cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tbChecker.sv
`default_nettype none

module tbChecker import cpuPkg::*; #(
  parameter int PROG_WORDS = 64,
  parameter int MEM_BYTES  = 256
) (
  input  logic     clk,
  input  logic     rstN,
  input  word_t    prog [PROG_WORDS],
  input  word_t    pc,
  input  logic     regWrEn,
  input  regAddr_t regWrAddr,
  input  word_t    regWrData,
  input  logic     memWrEn,
  input  word_t    memAddr,
  input  word_t    memWrData,
  input  logic     memByte,
  input  logic     illegal,
  input  int       testsDone,
  output int       errorCount,
  output int       checkCount,
  output int       failedTests
);

  localparam int PROG_IDX_W = $clog2(PROG_WORDS);
  localparam int MEM_IDX_W  = $clog2(MEM_BYTES);

  word_t      regModel [REG_COUNT];
  logic [7:0] memModel [MEM_BYTES];
  word_t      modelPc;
  word_t      curInstr;
  logic       expRegWrEn;
  logic       expMemWrEn;
  logic       expAccess;           // Load or store
  logic       expByte;
  logic       expIllegal;
  regAddr_t   expRegAddr;
  word_t      expRegData;
  word_t      expMemAddr;
  word_t      expMemData;
  word_t      expPcNext;
  int         errorsAtStart;
  int         checksAtStart;

  task automatic checkValue(input string name, input word_t expected, input word_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("** Error: %s expected %h, got %h (model pc %h, instr %h, time %0t)",
               name, expected, actual, modelPc, curInstr, $time);
    end
  endtask

  function automatic word_t readWord(input word_t addr);
    logic [MEM_IDX_W-3:0] w;
    w = addr[MEM_IDX_W-1:2];       // Low address bits ignored for words
    return {memModel[{w, 2'd3}], memModel[{w, 2'd2}], memModel[{w, 2'd1}], memModel[{w, 2'd0}]};
  endfunction

  // ISA semantics for the instruction at the model pc
  task automatic predict();
    opcode_t  op;
    regAddr_t rs;
    regAddr_t rt;
    word_t    ext;
    logic [7:0] b;
    curInstr   = prog[modelPc[PROG_IDX_W+1:2]];
    op         = opcode_t'(curInstr[OPCODE_HI:OPCODE_LO]);
    rs         = curInstr[RS_HI:RS_LO];
    rt         = curInstr[RT_HI:RT_LO];
    ext        = {{16{curInstr[15]}}, curInstr[IMM_HI:IMM_LO]};
    expRegWrEn = 1'b0;
    expMemWrEn = 1'b0;
    expAccess  = 1'b0;
    expByte    = 1'b0;
    expIllegal = 1'b0;
    expRegAddr = curInstr[RD_HI:RD_LO];
    expMemAddr = regModel[rs] + ext;
    expMemData = regModel[rt];
    expPcNext  = modelPc + 32'd4;
    b          = memModel[expMemAddr[MEM_IDX_W-1:0]];
    case (op)
      OP_ADD, OP_SUB, OP_MUL: begin
        expRegWrEn = 1'b1;
        expRegData = (op == OP_ADD) ? regModel[rs] + regModel[rt] :
                     (op == OP_SUB) ? regModel[rs] - regModel[rt] : regModel[rs] * regModel[rt];
      end
      OP_LDB, OP_LDW: begin
        expRegWrEn = 1'b1;
        expAccess  = 1'b1;
        expByte    = (op == OP_LDB);
        expRegAddr = rt;
        expRegData = expByte ? {{24{b[7]}}, b} : readWord(expMemAddr);
      end
      OP_STB, OP_STW: begin
        expMemWrEn = 1'b1;
        expAccess  = 1'b1;
        expByte    = (op == OP_STB);
      end
      OP_BEQ: begin
        if (regModel[rs] == regModel[rt]) expPcNext = modelPc + 32'd4 + (ext << 2);
      end
      OP_JUMP: expPcNext = {expPcNext[31:28], curInstr[TARGET_HI:TARGET_LO], 2'b00};
      default: expIllegal = 1'b1;  // No-op apart from the flag
    endcase
  endtask

  always @(negedge clk) begin
    if (!rstN) begin
      checkValue("pc", '0, pc);
      checkValue("regWrEn", '0, word_t'(regWrEn));
      checkValue("memWrEn", '0, word_t'(memWrEn));
    end else begin
      predict();
      checkValue("pc", modelPc, pc);
      checkValue("regWrEn", word_t'(expRegWrEn), word_t'(regWrEn));
      checkValue("memWrEn", word_t'(expMemWrEn), word_t'(memWrEn));
      checkValue("illegal", word_t'(expIllegal), word_t'(illegal));
      if (expRegWrEn) begin
        checkValue("regWrAddr", word_t'(expRegAddr), word_t'(regWrAddr));
        checkValue("regWrData", expRegData, regWrData);
      end
      if (expAccess) begin
        checkValue("memAddr", expMemAddr, memAddr);
        checkValue("memByte", word_t'(expByte), word_t'(memByte));
      end
      if (expMemWrEn) checkValue("memWrData", expMemData, memWrData);
    end
  end

  // Model state follows the DUT edge by edge
  always @(posedge clk or negedge rstN) begin
    logic [MEM_IDX_W-1:0] idx;
    if (!rstN) begin
      for (int i = 0; i < REG_COUNT; i++) regModel[i] = '0;
      for (int i = 0; i < MEM_BYTES; i++) memModel[i] = '0;
      modelPc = '0;
    end else begin
      idx = expMemAddr[MEM_IDX_W-1:0];
      if (expRegWrEn && expRegAddr != '0) regModel[expRegAddr] = expRegData;
      if (expMemWrEn && expByte) memModel[idx] = expMemData[7:0];
      if (expMemWrEn && !expByte) begin
        for (int k = 0; k < 4; k++) memModel[{idx[MEM_IDX_W-1:2], 2'(k)}] = expMemData[8*k +: 8];
      end
      modelPc = expPcNext;
    end
  end

  function automatic string testName(input int idx);
    case (idx)
      0: return "arithmetic";
      1: return "word access";
      2: return "byte access";
      3: return "control flow";
      default: return "mixed with illegal";
    endcase
  endfunction

  always @(testsDone) begin
    int testErrors;
    if (testsDone > 0) begin
      testErrors = errorCount - errorsAtStart;
      if (testErrors != 0) failedTests++;
      $display("Test %0d (%s): %s, %0d checks, %0d errors", testsDone - 1,
               testName(testsDone - 1), (testErrors == 0) ? "ok" : "mismatch",
               checkCount - checksAtStart, testErrors);
      errorsAtStart = errorCount;
      checksAtStart = checkCount;
    end
  end

endmodule

`default_nettype wire

// File: verification/tbClock.sv
`default_nettype none

module tbClock #(
  parameter int HALF_PERIOD  = 20,
  parameter int RESET_CYCLES = 5
) (
  input  logic startReset,   // Rising edge starts a new reset pulse
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset held low from power-up until the first request is served
  initial begin
    rstN = 1'b0;
    forever begin
      @(posedge startReset);
      rstN = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #2 rstN = 1'b1;            // Released just after the edge, like other inputs
    end
  end

endmodule

`default_nettype wire

// File: source/cpuCore.sv
`default_nettype none

module cpuCore import cpuPkg::*; #(
  parameter int MEM_BYTES = 256
) (
  input  logic     clk,
  input  logic     rstN,
  output word_t    pc,
  input  word_t    instr,
  output logic     regWrEn,
  output regAddr_t regWrAddr,
  output word_t    regWrData,
  output logic     memWrEn,
  output word_t    memAddr,
  output word_t    memWrData,
  output logic     memByte,
  output logic     illegal
);

  ctrlIf ctrlBus ();

  opcode_t  opcode;
  regAddr_t rsAddr;
  regAddr_t rtAddr;
  regAddr_t rdAddr;
  imm_t     imm;
  word_t    immExt;
  word_t    rsData;
  word_t    rtData;
  word_t    aluB;
  word_t    aluResult;
  logic     aluZero;
  word_t    memRdData;
  word_t    pcPlus4;
  word_t    branchTarget;
  word_t    jumpTarget;
  word_t    pcNext;

  // Field extraction
  assign opcode = opcode_t'(instr[OPCODE_HI:OPCODE_LO]);
  assign rsAddr = instr[RS_HI:RS_LO];
  assign rtAddr = instr[RT_HI:RT_LO];
  assign rdAddr = instr[RD_HI:RD_LO];
  assign imm    = instr[IMM_HI:IMM_LO];
  assign immExt = {{16{imm[15]}}, imm};

  control uControl (
    .opcode (opcode),
    .illegal(illegal),
    .ctrl   (ctrlBus.dec)
  );

  regFile uRegFile (
    .clk    (clk),
    .rstN   (rstN),
    .rdAddrA(rsAddr),
    .rdAddrB(rtAddr),
    .wrAddr (regWrAddr),
    .wrEn   (regWrEn),
    .wrData (regWrData),
    .rdDataA(rsData),
    .rdDataB(rtData)
  );

  assign aluB = ctrlBus.aluSrc ? immExt : rtData;   // Immediate for loads and stores

  alu uAlu (
    .op    (ctrlBus.aluOp),
    .a     (rsData),
    .b     (aluB),
    .result(aluResult),
    .zero  (aluZero)
  );

  dataMem #(
    .MEM_BYTES(MEM_BYTES)
  ) uDataMem (
    .clk   (clk),
    .rstN  (rstN),
    .addr  (aluResult),
    .wrData(rtData),
    .rdData(memRdData),
    .ctrl  (ctrlBus.mem)
  );

  // Write-back and observation ports
  assign regWrAddr = ctrlBus.regDst ? rdAddr : rtAddr;
  assign regWrData = ctrlBus.memToReg ? memRdData : aluResult;
  assign regWrEn   = rstN && ctrlBus.regWrite;    // Held low while in reset
  assign memWrEn   = rstN && ctrlBus.memWrite;
  assign memAddr   = aluResult;
  assign memWrData = rtData;
  assign memByte   = !ctrlBus.word;

  // Next PC
  assign pcPlus4      = pc + 32'd4;
  assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
  assign jumpTarget   = {pcPlus4[31:28], instr[TARGET_HI:TARGET_LO], 2'b00};

  always_comb begin
    if (ctrlBus.jump) begin
      pcNext = jumpTarget;                         // Jump has priority over branch bit
    end else if (ctrlBus.branch && aluZero) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
    else $error("cpuCore: pc %h is not word aligned", pc);

endmodule

`default_nettype wire

// File: source/dataMem.sv
`default_nettype none

module dataMem import cpuPkg::*; #(
  parameter int MEM_BYTES = 256
) (
  input  logic  clk,
  input  logic  rstN,
  input  word_t addr,
  input  word_t wrData,
  output word_t rdData,
  ctrlIf.mem    ctrl
);

  localparam int ADDR_W = $clog2(MEM_BYTES);

  if (MEM_BYTES < 4 || (MEM_BYTES & (MEM_BYTES - 1)) != 0) begin : gSizeCheck
    $error("dataMem: MEM_BYTES must be a power of two, at least 4");
  end

  logic [7:0]        mem [MEM_BYTES];
  logic [ADDR_W-1:0] byteIdx;       // Address modulo memory size
  logic [ADDR_W-3:0] wordBase;      // Low two bits dropped for words
  word_t             wordVal;
  word_t             byteVal;

  assign byteIdx  = addr[ADDR_W-1:0];
  assign wordBase = byteIdx[ADDR_W-1:2];

  // Little-endian word assembly
  assign wordVal = {mem[{wordBase, 2'd3}], mem[{wordBase, 2'd2}],
                    mem[{wordBase, 2'd1}], mem[{wordBase, 2'd0}]};
  assign byteVal = {{24{mem[byteIdx][7]}}, mem[byteIdx]};

  assign rdData = !ctrl.memRead ? '0 : (ctrl.word ? wordVal : byteVal);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < MEM_BYTES; i++) begin
        mem[i] <= '0;
      end
    end else if (ctrl.memWrite) begin
      if (ctrl.word) begin
        mem[{wordBase, 2'd0}] <= wrData[7:0];
        mem[{wordBase, 2'd1}] <= wrData[15:8];
        mem[{wordBase, 2'd2}] <= wrData[23:16];
        mem[{wordBase, 2'd3}] <= wrData[31:24];
      end else begin
        mem[byteIdx] <= wrData[7:0];      // Single byte only
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) !(ctrl.memRead && ctrl.memWrite))
    else $error("dataMem: read and write requested together");

endmodule

`default_nettype wire

// File: source/alu.sv
`default_nettype none

module alu import cpuPkg::*; (
  input  aluOp_t op,
  input  word_t  a,
  input  word_t  b,
  output word_t  result,
  output logic   zero
);

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;       // Also address generation
      ALU_SUB: result = a - b;
      ALU_MUL: result = a * b;       // Low 32 bits of the product
      default: result = '0;
    endcase
  end

  // Equal operands on SUB, used by BEQ
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: source/regFile.sv
`default_nettype none

module regFile import cpuPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  regAddr_t rdAddrA,
  input  regAddr_t rdAddrB,
  input  regAddr_t wrAddr,
  input  logic     wrEn,
  input  word_t    wrData,
  output word_t    rdDataA,
  output word_t    rdDataB
);

  word_t regs [1:REG_COUNT-1];   // Register 0 has no storage

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && wrAddr != '0) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Reads see the value before this cycle's write
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// File: source/control.sv
`default_nettype none

module control import cpuPkg::*; (
  input  opcode_t opcode,
  output logic    illegal,
  ctrlIf.dec      ctrl
);

  // {regDst, branch, memRead, memToReg, memWrite, aluSrc, regWrite, jump, word}
  logic [8:0] bits;
  aluOp_t     op;

  always_comb begin
    bits    = '0;
    op      = ALU_ADD;
    illegal = 1'b0;
    case (opcode)
      OP_ADD: begin
        bits = 9'b100000100;
      end
      OP_SUB: begin
        bits = 9'b100000100;
        op   = ALU_SUB;
      end
      OP_MUL: begin
        bits = 9'b100000100;
        op   = ALU_MUL;
      end
      OP_LDB: begin
        bits = 9'b001101100;       // Byte load, sign extended in memory
      end
      OP_LDW: begin
        bits = 9'b001101101;
      end
      OP_STB: begin
        bits = 9'b000011000;
      end
      OP_STW: begin
        bits = 9'b000011001;
      end
      OP_BEQ: begin
        bits = 9'b010000000;
        op   = ALU_SUB;            // Compare through zero flag
      end
      OP_JUMP: begin
        bits = 9'b010000010;       // Branch bit kept, jump wins in next-PC logic
      end
      default: begin
        illegal = 1'b1;            // Acts as a no-op
      end
    endcase
  end

  assign {ctrl.regDst, ctrl.branch, ctrl.memRead, ctrl.memToReg, ctrl.memWrite,
          ctrl.aluSrc, ctrl.regWrite, ctrl.jump, ctrl.word} = bits;
  assign ctrl.aluOp = op;

  // A store never also writes the register file
  always_comb begin
    assert (!(ctrl.memWrite && ctrl.regWrite))
      else $error("control: memWrite and regWrite both set for opcode %h", opcode);
  end

endmodule

`default_nettype wire

// File: source/ctrlIf.sv
`default_nettype none

interface ctrlIf import cpuPkg::*; ();

  logic   regDst;     // Destination is rd, not rt
  logic   branch;
  logic   memRead;
  logic   memToReg;   // Write back load data
  logic   memWrite;
  logic   aluSrc;     // Second operand is the immediate
  logic   regWrite;
  logic   jump;
  logic   word;       // Word access, else byte
  aluOp_t aluOp;

  modport dec (output regDst, branch, memRead, memToReg, memWrite, aluSrc,
               regWrite, jump, word, aluOp);

  modport dp (input regDst, aluSrc, branch, jump, memToReg, regWrite, aluOp);

  modport mem (input memRead, memWrite, word);

endinterface

`default_nettype wire

// File: source/cpuPkg.sv
`default_nettype none

package cpuPkg;

  localparam int WORD_W    = 32;
  localparam int REG_COUNT = 32;            // Fixed by the 5-bit register fields

  typedef logic [WORD_W-1:0]            word_t;
  typedef logic [$clog2(REG_COUNT)-1:0] regAddr_t;
  typedef logic [15:0]                  imm_t;

  typedef enum logic [5:0] {
    OP_ADD  = 6'h00,
    OP_SUB  = 6'h01,
    OP_MUL  = 6'h02,
    OP_LDB  = 6'h10,
    OP_LDW  = 6'h11,
    OP_STB  = 6'h12,
    OP_STW  = 6'h13,
    OP_BEQ  = 6'h30,
    OP_JUMP = 6'h31
  } opcode_t;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_MUL = 2'd2
  } aluOp_t;

  // Instruction field positions
  localparam int OPCODE_HI = 31;
  localparam int OPCODE_LO = 26;
  localparam int RS_HI     = 25;
  localparam int RS_LO     = 21;
  localparam int RT_HI     = 20;
  localparam int RT_LO     = 16;
  localparam int RD_HI     = 15;
  localparam int RD_LO     = 11;
  localparam int IMM_HI    = 15;
  localparam int IMM_LO    = 0;
  localparam int TARGET_HI = 25;
  localparam int TARGET_LO = 0;

endpackage

`default_nettype wire
